// ==== copy_pkg.sv ====
// Copy subsystem shared types
package copy_pkg;

    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int LEN_W      = 8;
    localparam int STRB_W     = DATA_W / 8;
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [1:0]        resp_t;

    // SRAM window in the byte address map
    localparam addr_t SRAM_BASE  = 16'h1000;
    localparam addr_t SRAM_BYTES = addr_t'(SRAM_WORDS * STRB_W);

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        addr_t src;
        addr_t dst;
        len_t  len;
    } copy_cmd_t;

    typedef struct packed {
        data_t data;
        logic  err;
    } fifo_item_t;

    // Manager to subordinate
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } axil_req_t;

    // Subordinate to manager
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } axil_rsp_t;

endpackage

// ==== copy_reader.sv ====
// Copy engine source reader
`timescale 1ns/10ps

module copy_reader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  copy_pkg::copy_cmd_t  cmd,
    output logic                 busy,
    output copy_pkg::axil_req_t  rd_req,
    input  copy_pkg::axil_rsp_t  rd_rsp,
    output logic                 push,
    output copy_pkg::fifo_item_t push_item,
    input  logic                 fifo_space
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        WAIT
    } state_t;

    state_t          state;
    copy_pkg::addr_t src;
    copy_pkg::len_t  remain;
    logic            ar_valid_q;
    logic            last;

    assign last = (remain == copy_pkg::len_t'(1));
    assign busy = (state != IDLE);
    assign push = (state == WAIT) && rd_rsp.r_valid;

    // Any non-OKAY read marks the word as bad
    assign push_item = '{
        data: rd_rsp.r_data,
        err:  (rd_rsp.r_resp != copy_pkg::RESP_OKAY)
    };

    always_comb begin
        rd_req          = '0;
        rd_req.ar_valid = ar_valid_q;
        rd_req.ar_addr  = src;
        rd_req.r_ready  = (state == WAIT);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            src        <= '0;
            remain     <= '0;
            ar_valid_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start && cmd.len != '0) begin
                        src        <= cmd.src;
                        remain     <= cmd.len;
                        ar_valid_q <= fifo_space;
                        state      <= ADDR;
                    end
                end
                ADDR: begin
                    // Valid stays up once raised, until AR completes
                    if (ar_valid_q && rd_rsp.ar_ready) begin
                        ar_valid_q <= 1'b0;
                        state      <= WAIT;
                    end else if (fifo_space) begin
                        ar_valid_q <= 1'b1;
                    end
                end
                WAIT: begin
                    if (rd_rsp.r_valid) begin
                        src    <= src + copy_pkg::addr_t'(copy_pkg::STRB_W);
                        remain <= remain - copy_pkg::len_t'(1);
                        if (last) begin
                            state <= IDLE;
                        end else begin
                            // Space already counts the word arriving now
                            ar_valid_q <= fifo_space;
                            state      <= ADDR;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== copy_fifo.sv ====
// Read data buffer between reader and writer
`timescale 1ns/10ps

module copy_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  copy_pkg::fifo_item_t push_item,
    input  logic                 pop,
    output copy_pkg::fifo_item_t pop_item,
    output logic                 empty,
    output logic                 space,
    input  logic                 rd_pending
);

    copy_pkg::fifo_item_t                mem [copy_pkg::FIFO_DEPTH];
    logic [copy_pkg::FIFO_PTR_W-1:0]     wr_ptr;
    logic [copy_pkg::FIFO_PTR_W-1:0]     rd_ptr;
    logic [copy_pkg::FIFO_CNT_W-1:0]     count;

    assign pop_item = mem[rd_ptr];
    assign empty    = (count == '0);

    // A read in flight owns one slot already
    assign space = (count + copy_pkg::FIFO_CNT_W'(rd_pending))
                   < copy_pkg::FIFO_CNT_W'(copy_pkg::FIFO_DEPTH);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== copy_writer.sv ====
// Copy engine destination writer
`timescale 1ns/10ps

module copy_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  copy_pkg::copy_cmd_t  cmd,
    output logic                 busy,
    output copy_pkg::axil_req_t  wr_req,
    input  copy_pkg::axil_rsp_t  wr_rsp,
    output logic                 pop,
    input  copy_pkg::fifo_item_t pop_item,
    input  logic                 empty,
    output logic                 done,
    output logic                 done_err
);

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        RESP,
        FINISH
    } state_t;

    state_t          state;
    copy_pkg::addr_t dst;
    copy_pkg::len_t  remain;
    logic            err_q;
    logic            last;

    assign last     = (remain == copy_pkg::len_t'(1));
    assign busy     = (state != IDLE);
    assign done     = (state == FINISH);
    assign done_err = err_q;

    // Head item leaves the FIFO only once its write is answered
    assign pop = (state == RESP) && wr_rsp.b_valid;

    always_comb begin
        wr_req          = '0;
        wr_req.aw_valid = (state == SEND) && !empty;
        wr_req.aw_addr  = dst;
        wr_req.w_valid  = (state == SEND) && !empty;
        wr_req.w_data   = pop_item.data;
        wr_req.w_strb   = '1;
        wr_req.b_ready  = (state == RESP);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            dst    <= '0;
            remain <= '0;
            err_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        dst    <= cmd.dst;
                        remain <= cmd.len;
                        err_q  <= 1'b0;
                        state  <= (cmd.len == '0) ? FINISH : SEND;
                    end
                end
                SEND: begin
                    if (wr_req.aw_valid && wr_rsp.aw_ready) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (wr_rsp.b_valid) begin
                        err_q  <= err_q | pop_item.err
                                  | (wr_rsp.b_resp != copy_pkg::RESP_OKAY);
                        dst    <= dst + copy_pkg::addr_t'(copy_pkg::STRB_W);
                        remain <= remain - copy_pkg::len_t'(1);
                        state  <= last ? FINISH : SEND;
                    end
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== axil_window_decode.sv ====
// Host and engine access to the SRAM window
`timescale 1ns/10ps

module axil_window_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  copy_pkg::axil_req_t host_req,
    output copy_pkg::axil_rsp_t host_rsp,
    input  copy_pkg::axil_req_t eng_req,
    output copy_pkg::axil_rsp_t eng_rsp,
    output copy_pkg::axil_req_t mem_req,
    input  copy_pkg::axil_rsp_t mem_rsp
);

    // Grant state per channel, owner and miss held until the response
    logic                rd_busy, rd_host, rd_miss;
    logic                wr_busy, wr_host, wr_miss;
    logic                rd_sel_host, wr_sel_host;
    copy_pkg::axil_req_t rd_sel, wr_sel;
    logic                ar_hit, aw_hit;
    logic                ar_go, aw_go;
    logic                ar_acc, aw_acc;
    logic                r_valid, b_valid;
    copy_pkg::data_t     r_data;
    copy_pkg::resp_t     r_resp, b_resp;

    function automatic logic in_window(copy_pkg::addr_t addr);
        copy_pkg::addr_t off;
        off = addr - copy_pkg::SRAM_BASE;
        return off < copy_pkg::SRAM_BYTES;
    endfunction

    // Host wins an idle channel
    assign rd_sel_host = rd_busy ? rd_host : host_req.ar_valid;
    assign wr_sel_host = wr_busy ? wr_host : host_req.aw_valid;
    assign rd_sel      = rd_sel_host ? host_req : eng_req;
    assign wr_sel      = wr_sel_host ? host_req : eng_req;

    assign ar_hit = in_window(rd_sel.ar_addr);
    assign aw_hit = in_window(wr_sel.aw_addr);
    assign ar_go  = !rd_busy && rd_sel.ar_valid;
    assign aw_go  = !wr_busy && wr_sel.aw_valid && wr_sel.w_valid;

    always_comb begin
        mem_req          = '0;
        mem_req.ar_valid = ar_go && ar_hit;
        mem_req.ar_addr  = rd_sel.ar_addr - copy_pkg::SRAM_BASE;
        mem_req.r_ready  = rd_busy && !rd_miss && rd_sel.r_ready;
        mem_req.aw_valid = aw_go && aw_hit;
        mem_req.aw_addr  = wr_sel.aw_addr - copy_pkg::SRAM_BASE;
        mem_req.w_valid  = aw_go && aw_hit;
        mem_req.w_data   = wr_sel.w_data;
        mem_req.w_strb   = wr_sel.w_strb;
        mem_req.b_ready  = wr_busy && !wr_miss && wr_sel.b_ready;
    end

    // Misses are taken at once and answered by the decoder
    assign ar_acc  = ar_go && (!ar_hit || mem_rsp.ar_ready);
    assign aw_acc  = aw_go && (!aw_hit || mem_rsp.aw_ready);
    assign r_valid = rd_busy && (rd_miss || mem_rsp.r_valid);
    assign b_valid = wr_busy && (wr_miss || mem_rsp.b_valid);
    assign r_data  = rd_miss ? '0 : mem_rsp.r_data;
    assign r_resp  = rd_miss ? copy_pkg::RESP_DECERR : mem_rsp.r_resp;
    assign b_resp  = wr_miss ? copy_pkg::RESP_DECERR : mem_rsp.b_resp;

    assign host_rsp = '{
        aw_ready: wr_sel_host && aw_acc,
        w_ready:  wr_sel_host && aw_acc,
        b_valid:  wr_sel_host && b_valid,
        b_resp:   b_resp,
        ar_ready: rd_sel_host && ar_acc,
        r_valid:  rd_sel_host && r_valid,
        r_data:   r_data,
        r_resp:   r_resp
    };

    assign eng_rsp = '{
        aw_ready: !wr_sel_host && aw_acc,
        w_ready:  !wr_sel_host && aw_acc,
        b_valid:  !wr_sel_host && b_valid,
        b_resp:   b_resp,
        ar_ready: !rd_sel_host && ar_acc,
        r_valid:  !rd_sel_host && r_valid,
        r_data:   r_data,
        r_resp:   r_resp
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy <= 1'b0;
            rd_host <= 1'b0;
            rd_miss <= 1'b0;
            wr_busy <= 1'b0;
            wr_host <= 1'b0;
            wr_miss <= 1'b0;
        end else begin
            if (ar_acc) begin
                rd_busy <= 1'b1;
                rd_host <= rd_sel_host;
                rd_miss <= !ar_hit;
            end else if (r_valid && rd_sel.r_ready) begin
                rd_busy <= 1'b0;
            end
            if (aw_acc) begin
                wr_busy <= 1'b1;
                wr_host <= wr_sel_host;
                wr_miss <= !aw_hit;
            end else if (b_valid && wr_sel.b_ready) begin
                wr_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== axil_sram.sv ====
// AXI4-Lite word SRAM with byte strobes
`timescale 1ns/10ps

module axil_sram (
    input  logic                clk,
    input  logic                rst_n,
    input  copy_pkg::axil_req_t req,
    output copy_pkg::axil_rsp_t rsp
);

    copy_pkg::data_t                 mem [copy_pkg::SRAM_WORDS];
    logic [copy_pkg::SRAM_IDX_W-1:0] raddr;
    logic [copy_pkg::SRAM_IDX_W-1:0] waddr;
    logic                            ar_fire;
    logic                            wr_fire;
    logic                            r_valid_q;
    logic                            b_valid_q;
    copy_pkg::data_t                 r_data_q;

    assign raddr = req.ar_addr[copy_pkg::SRAM_IDX_W+1:2];
    assign waddr = req.aw_addr[copy_pkg::SRAM_IDX_W+1:2];

    // No new request while the previous response is still waiting
    assign ar_fire = req.ar_valid && !r_valid_q;
    assign wr_fire = req.aw_valid && req.w_valid && !b_valid_q;

    assign rsp = '{
        aw_ready: wr_fire,
        w_ready:  wr_fire,
        b_valid:  b_valid_q,
        b_resp:   copy_pkg::RESP_OKAY,
        ar_ready: !r_valid_q,
        r_valid:  r_valid_q,
        r_data:   r_data_q,
        r_resp:   copy_pkg::RESP_OKAY
    };

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < copy_pkg::STRB_W; i++) begin
                if (req.w_strb[i]) begin
                    mem[waddr][8*i +: 8] <= req.w_data[8*i +: 8];
                end
            end
        end
        if (ar_fire) begin
            r_data_q <= mem[raddr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_fire) begin
                r_valid_q <= 1'b1;
            end else if (req.r_ready) begin
                r_valid_q <= 1'b0;
            end
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (req.b_ready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

endmodule

// ==== copy_subsys_top.sv ====
// Copy subsystem top level
`timescale 1ns/10ps

module copy_subsys_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  copy_pkg::copy_cmd_t cmd,
    output logic                done,
    output logic                done_err,
    input  copy_pkg::axil_req_t host_req,
    output copy_pkg::axil_rsp_t host_rsp
);

    logic                 start;
    logic                 rd_busy;
    logic                 wr_busy;
    logic                 push;
    logic                 pop;
    logic                 empty;
    logic                 fifo_space;
    copy_pkg::fifo_item_t push_item;
    copy_pkg::fifo_item_t pop_item;
    copy_pkg::axil_req_t  rd_req;
    copy_pkg::axil_req_t  wr_req;
    copy_pkg::axil_req_t  eng_req;
    copy_pkg::axil_req_t  mem_req;
    copy_pkg::axil_rsp_t  eng_rsp;
    copy_pkg::axil_rsp_t  mem_rsp;

    assign cmd_ready = !(rd_busy || wr_busy);
    assign start     = cmd_valid && cmd_ready;

    // Reader owns the read channel, writer the write channel
    assign eng_req = '{
        aw_valid: wr_req.aw_valid,
        aw_addr:  wr_req.aw_addr,
        w_valid:  wr_req.w_valid,
        w_data:   wr_req.w_data,
        w_strb:   wr_req.w_strb,
        b_ready:  wr_req.b_ready,
        ar_valid: rd_req.ar_valid,
        ar_addr:  rd_req.ar_addr,
        r_ready:  rd_req.r_ready
    };

    copy_reader u_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cmd        (cmd),
        .busy       (rd_busy),
        .rd_req     (rd_req),
        .rd_rsp     (eng_rsp),
        .push       (push),
        .push_item  (push_item),
        .fifo_space (fifo_space)
    );

    copy_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_item  (push_item),
        .pop        (pop),
        .pop_item   (pop_item),
        .empty      (empty),
        .space      (fifo_space),
        .rd_pending (rd_req.r_ready)
    );

    copy_writer u_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .cmd      (cmd),
        .busy     (wr_busy),
        .wr_req   (wr_req),
        .wr_rsp   (eng_rsp),
        .pop      (pop),
        .pop_item (pop_item),
        .empty    (empty),
        .done     (done),
        .done_err (done_err)
    );

    axil_window_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .eng_req  (eng_req),
        .eng_rsp  (eng_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    axil_sram u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

// ==== copy_subsys_sva.sv ====
// Copy subsystem handshake assertions
`timescale 1ns/10ps

module copy_subsys_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                done,
    input copy_pkg::axil_req_t eng_req,
    input copy_pkg::axil_rsp_t eng_rsp,
    input copy_pkg::axil_req_t mem_req,
    input copy_pkg::axil_rsp_t mem_rsp
);

    // Engine read address held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        eng_req.ar_valid && !eng_rsp.ar_ready
        |=> eng_req.ar_valid && $stable(eng_req.ar_addr))
        else $error("engine AR changed before acceptance");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        eng_req.aw_valid && !eng_rsp.aw_ready
        |=> eng_req.aw_valid && eng_req.w_valid && $stable(eng_req.aw_addr)
            && $stable(eng_req.w_data))
        else $error("engine AW or W changed before acceptance");

    // SRAM responses wait for their ready
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.r_valid && !mem_req.r_ready |=> mem_rsp.r_valid && $stable(mem_rsp.r_data))
        else $error("SRAM read response changed before handshake");

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.b_valid && !mem_req.b_ready |=> mem_rsp.b_valid)
        else $error("SRAM write response dropped before handshake");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !done && !eng_req.ar_valid && !eng_req.aw_valid
                   && !mem_rsp.r_valid && !mem_rsp.b_valid)
        else $error("valid output high during reset");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done high for two cycles");

endmodule

bind copy_subsys_top copy_subsys_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .done    (done),
    .eng_req (eng_req),
    .eng_rsp (eng_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
);

// ==== tb_copy_subsys.sv ====
// Copy subsystem testbench
`timescale 1ns/10ps

module tb_copy_subsys;

    localparam int LIMIT = 2000;

    logic                clk;
    logic                rst_n;
    logic                cmd_valid;
    logic                cmd_ready;
    copy_pkg::copy_cmd_t cmd;
    logic                done;
    logic                done_err;
    copy_pkg::axil_req_t host_req;
    copy_pkg::axil_rsp_t host_rsp;

    // Expected SRAM contents, one entry per word
    copy_pkg::data_t model [copy_pkg::SRAM_WORDS];
    logic [31:0]     lfsr;
    int              errors;
    int              checks;
    int              mark;

    copy_subsys_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .done      (done),
        .done_err  (done_err),
        .host_req  (host_req),
        .host_rsp  (host_rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic copy_pkg::addr_t word_addr(int idx);
        return copy_pkg::addr_t'(copy_pkg::SRAM_BASE + copy_pkg::addr_t'(idx * 4));
    endfunction

    // Only strobed byte lanes take the new data
    function automatic copy_pkg::data_t apply_strobes(copy_pkg::data_t old,
                                                      copy_pkg::data_t wdata,
                                                      copy_pkg::strb_t strb);
        copy_pkg::data_t v;
        v = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                v[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got=%h expected=%h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - mark);
        mark = errors;
    endtask

    task automatic host_write(input copy_pkg::addr_t addr, input copy_pkg::data_t data,
                              input copy_pkg::strb_t strb, output copy_pkg::resp_t resp);
        int n;
        @(posedge clk);
        host_req.aw_valid <= 1'b1;
        host_req.aw_addr  <= addr;
        host_req.w_valid  <= 1'b1;
        host_req.w_data   <= data;
        host_req.w_strb   <= strb;
        host_req.b_ready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!host_rsp.aw_ready && !host_rsp.w_ready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!host_rsp.aw_ready && !host_rsp.w_ready) begin
            note_timeout("host write address and data");
        end else begin
            // AW and W are taken in the same cycle
            check("aw_ready", 32'(host_rsp.aw_ready), 32'h1);
            check("w_ready", 32'(host_rsp.w_ready), 32'h1);
        end
        @(posedge clk);
        host_req.aw_valid <= 1'b0;
        host_req.w_valid  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!host_rsp.b_valid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!host_rsp.b_valid) begin
            note_timeout("host write response");
        end
        resp = host_rsp.b_resp;
        @(posedge clk);
        host_req.b_ready <= 1'b0;
    endtask

    task automatic host_read(input copy_pkg::addr_t addr, output copy_pkg::data_t data,
                             output copy_pkg::resp_t resp);
        int n;
        @(posedge clk);
        host_req.ar_valid <= 1'b1;
        host_req.ar_addr  <= addr;
        host_req.r_ready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!host_rsp.ar_ready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!host_rsp.ar_ready) begin
            note_timeout("host read address");
        end
        @(posedge clk);
        host_req.ar_valid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!host_rsp.r_valid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!host_rsp.r_valid) begin
            note_timeout("host read data");
        end
        data = host_rsp.r_data;
        resp = host_rsp.r_resp;
        @(posedge clk);
        host_req.r_ready <= 1'b0;
    endtask

    // Engine stays busy from acceptance until the done pulse
    task automatic run_copy(input copy_pkg::addr_t src_addr, input copy_pkg::addr_t dst_addr,
                            input copy_pkg::len_t n_words, output logic err,
                            output int cycles);
        int n;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= '{src: src_addr, dst: dst_addr, len: n_words};
        n = 0;
        @(negedge clk);
        while (!cmd_ready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ready) begin
            note_timeout("command acceptance");
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!done && n < LIMIT) begin
            check("cmd_ready", 32'(cmd_ready), 32'h0);
            @(negedge clk);
            n++;
        end
        if (!done) begin
            note_timeout("copy done");
        end
        check("cmd_ready", 32'(cmd_ready), 32'h0);
        err    = done_err;
        cycles = n + 1;
        @(negedge clk);
        check("cmd_ready", 32'(cmd_ready), 32'h1);
        check("done", 32'(done), 32'h0);
    endtask

    task automatic preload_random(input int idx, input int n);
        copy_pkg::data_t wdata;
        copy_pkg::resp_t resp;
        for (int i = 0; i < n; i++) begin
            wdata = rand_bits(32);
            host_write(word_addr(idx + i), wdata, 4'hf, resp);
            check("b_resp", 32'(resp), 32'(copy_pkg::RESP_OKAY));
            model[idx + i] = wdata;
        end
    endtask

    task automatic verify_region(input int idx, input int n);
        copy_pkg::data_t data;
        copy_pkg::resp_t resp;
        for (int i = 0; i < n; i++) begin
            host_read(word_addr(idx + i), data, resp);
            check("r_data", data, model[idx + i]);
            check("r_resp", 32'(resp), 32'(copy_pkg::RESP_OKAY));
        end
    endtask

    // Random strobed writes each followed by a read back
    task automatic host_traffic(input int base, input int n);
        copy_pkg::data_t wdata;
        copy_pkg::data_t data;
        copy_pkg::strb_t strb;
        copy_pkg::resp_t resp;
        int              idx;
        for (int i = 0; i < n; i++) begin
            idx   = base + int'(rand_bits(5));
            wdata = rand_bits(32);
            strb  = copy_pkg::strb_t'(rand_bits(4));
            host_write(word_addr(idx), wdata, strb, resp);
            check("b_resp", 32'(resp), 32'(copy_pkg::RESP_OKAY));
            model[idx] = apply_strobes(model[idx], wdata, strb);
            host_read(word_addr(idx), data, resp);
            check("r_data", data, model[idx]);
            check("r_resp", 32'(resp), 32'(copy_pkg::RESP_OKAY));
        end
    endtask

    initial begin
        copy_pkg::resp_t resp;
        copy_pkg::data_t data;
        copy_pkg::data_t wdata;
        copy_pkg::addr_t addr;
        logic            err;
        int              cycles;
        int              src_idx;
        int              dst_idx;
        int              len;

        lfsr      = 32'hdccb8b9c;
        errors    = 0;
        checks    = 0;
        mark      = 0;
        rst_n     <= 1'b0;
        cmd_valid <= 1'b0;
        cmd       <= '0;
        host_req  <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("cmd_ready", 32'(cmd_ready), 32'h1);
        check("done", 32'(done), 32'h0);

        // Fill pattern built from the whole word address
        for (int i = 0; i < copy_pkg::SRAM_WORDS; i++) begin
            addr  = word_addr(i);
            wdata = {~addr, addr ^ 16'h5a3c};
            host_write(addr, wdata, 4'hf, resp);
            check("b_resp", 32'(resp), 32'(copy_pkg::RESP_OKAY));
            model[i] = wdata;
        end
        report_test("reset and preload");

        host_traffic(0, 8);
        host_traffic(96, 8);
        host_traffic(160, 8);
        report_test("host round trip");

        len     = 1 + int'(rand_bits(4));
        src_idx = int'(rand_bits(6));
        dst_idx = 128 + int'(rand_bits(6));
        preload_random(src_idx, len);
        run_copy(word_addr(src_idx), word_addr(dst_idx), copy_pkg::len_t'(len), err, cycles);
        check("done_err", 32'(err), 32'h0);
        for (int i = 0; i < len; i++) begin
            model[dst_idx + i] = model[src_idx + i];
        end
        verify_region(dst_idx, len);
        report_test("copy job");

        // Below the window on even passes, far above it on odd ones
        for (int i = 0; i < 6; i++) begin
            addr = copy_pkg::addr_t'(rand_bits(14));
            addr = i[0] ? (addr | 16'h4000) & 16'hfffc : addr & 16'h0ffc;
            if (i == 5) begin
                addr = 16'h1400;
            end
            host_write(addr, rand_bits(32), 4'hf, resp);
            check("b_resp", 32'(resp), 32'(copy_pkg::RESP_DECERR));
            host_read(addr, data, resp);
            check("r_data", data, 32'h0);
            check("r_resp", 32'(resp), 32'(copy_pkg::RESP_DECERR));
        end
        dst_idx = 210;
        run_copy(16'h0800, word_addr(dst_idx), 8'd4, err, cycles);
        check("done_err", 32'(err), 32'h1);
        for (int i = 0; i < 4; i++) begin
            model[dst_idx + i] = '0;
        end
        verify_region(dst_idx, 4);
        report_test("out of window");

        src_idx = 0;
        dst_idx = 64;
        len     = 48;
        preload_random(src_idx, len);
        fork
            run_copy(word_addr(src_idx), word_addr(dst_idx), copy_pkg::len_t'(len), err,
                     cycles);
            host_traffic(224, 16);
        join
        check("done_err", 32'(err), 32'h0);
        for (int i = 0; i < len; i++) begin
            model[dst_idx + i] = model[src_idx + i];
        end
        verify_region(dst_idx, len);
        report_test("concurrent host traffic");

        dst_idx = 100;
        run_copy(word_addr(16), word_addr(dst_idx), 8'd0, err, cycles);
        check("done_err", 32'(err), 32'h0);
        check("done latency", 32'(cycles), 32'h1);
        verify_region(dst_idx, 4);
        report_test("zero length");

        @(negedge clk);
        check("cmd_ready", 32'(cmd_ready), 32'h1);
        run_copy(word_addr(40), word_addr(240), 8'd5, err, cycles);
        check("done_err", 32'(err), 32'h0);
        for (int i = 0; i < 5; i++) begin
            model[240 + i] = model[40 + i];
        end
        verify_region(240, 5);
        report_test("command gating");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
copy_pkg.sv
copy_reader.sv
copy_fifo.sv
copy_writer.sv
axil_window_decode.sv
axil_sram.sv
copy_subsys_top.sv
copy_subsys_sva.sv
tb_copy_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_copy_subsys -f verilog.f -o sim_copy_subsys

./obj_dir/sim_copy_subsys | tee sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
fi
echo "Simulation did not report success, see sim.log"
exit 1
